// File: filelist.f
+incdir+hw
hw/rvPkg.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/instructionFetch.sv
hw/loadStoreUnit.sv
hw/busArbiter.sv
hw/coreControl.sv
hw/rvCore.sv
verification/wbMemoryModel.sv
verification/rvCoreTb.sv

// File: hw/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module aluUnit (
  input  wire rvPkg::aluOp_e       aluOp,
  input  wire [`RV_XLEN-1:0]       aluX,
  input  wire [`RV_XLEN-1:0]       aluY,
  output logic [`RV_XLEN-1:0]      aluResult
);

  logic [4:0] shamt;

  assign shamt = aluY[4:0];

  always_comb
  begin
    aluResult = '0;
    case (aluOp)
      rvPkg::Add: aluResult = aluX + aluY;
      rvPkg::Sub: aluResult = aluX - aluY;
      rvPkg::Or:  aluResult = aluX | aluY;
      rvPkg::Xor: aluResult = aluX ^ aluY;
      rvPkg::And: aluResult = aluX & aluY;
      rvPkg::SrU: aluResult = aluX >> shamt;
      rvPkg::SrS: aluResult = $signed(aluX) >>> shamt;
      rvPkg::Sl:  aluResult = aluX << shamt;
      // Compares yield 0 or 1
      rvPkg::LtU: aluResult[0] = aluX < aluY;
      rvPkg::LtS: aluResult[0] = $signed(aluX) < $signed(aluY);
      rvPkg::GeU: aluResult[0] = aluX >= aluY;
      rvPkg::GeS: aluResult[0] = $signed(aluX) >= $signed(aluY);
      rvPkg::Eq:  aluResult[0] = aluX == aluY;
      rvPkg::Ne:  aluResult[0] = aluX != aluY;
      default:    aluResult = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module busArbiter (
  input  wire                  clk,
  input  wire                  reset,
  input  wire rvPkg::wbReq_t   fetchReq,
  output rvPkg::wbResp_t       fetchResp,
  input  wire rvPkg::wbReq_t   dataReq,
  output rvPkg::wbResp_t       dataResp,
  output rvPkg::wbReq_t        busReq,
  input  wire rvPkg::wbResp_t  busResp
);

  logic grantValid;
  logic grantData;   // Owner is the data port
  logic pickData;
  logic ownerAck;

  // Held grant wins, an idle arbiter prefers data
  assign pickData = grantValid ? grantData : dataReq.cyc;
  assign busReq   = pickData ? dataReq : fetchReq;
  assign ownerAck = busResp.ack && busReq.cyc;

  always_comb
  begin
    fetchResp.datR = busResp.datR;
    fetchResp.ack  = ownerAck && !pickData;
    dataResp.datR  = busResp.datR;
    dataResp.ack   = ownerAck && pickData;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      grantValid <= 1'b0;
      grantData  <= 1'b0;
    end
    else if (grantValid)
    begin
      if (busResp.ack)
        grantValid <= 1'b0;
    end
    else if (busReq.cyc && !busResp.ack)
    begin
      // Zero wait ack needs no held grant
      grantValid <= 1'b1;
      grantData  <= pickData;
    end
  end

endmodule

`default_nettype wire

// File: hw/coreControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module coreControl (
  input  wire                           clk,
  input  wire                           reset,
  output logic                          fetchStart,
  input  wire                           fetchDone,
  input  wire [`RV_XLEN-1:0]            instrWord,
  input  wire [`RV_XLEN-1:0]            pc,
  output rvPkg::pcCmd_t                 pcCmd,
  output logic [`RV_REG_BITS-1:0]       rs1,
  output logic [`RV_REG_BITS-1:0]       rs2,
  output logic [`RV_REG_BITS-1:0]       rd,
  input  wire [`RV_XLEN-1:0]            rs1Data,
  input  wire [`RV_XLEN-1:0]            rs2Data,
  output logic                          regWrite,
  output logic [`RV_XLEN-1:0]           writeData,
  output rvPkg::aluOp_e                 aluOp,
  output logic [`RV_XLEN-1:0]           aluX,
  output logic [`RV_XLEN-1:0]           aluY,
  input  wire [`RV_XLEN-1:0]            aluResult,
  output rvPkg::memCmd_t                memCmd,
  input  wire                           memDone,
  input  wire [`RV_XLEN-1:0]            loadData,
  output logic [63:0]                   retiredCount
);

  rvPkg::ctrlState_e     state;
  rvPkg::decodedInstr_t  instr;
  logic                  fetchPending;
  logic                  writesRd;
  logic                  isMem;
  logic [`RV_XLEN-1:0]   resultReg;   // Value for rd in Writeback
  logic [`RV_XLEN-1:0]   targetReg;   // Redirect destination

  function automatic rvPkg::decodedInstr_t decodeWord(input logic [`RV_XLEN-1:0] w);
    rvPkg::decodedInstr_t d;
    d.opcode   = rvPkg::opcode_e'(w[`RV_OPCODE_LSB +: 7]);
    d.funct3   = w[`RV_FUNCT3_LSB +: 3];
    d.funct7b5 = w[`RV_FUNCT7B5_BIT];
    d.rd       = w[`RV_RD_LSB +: `RV_REG_BITS];
    d.rs1      = w[`RV_RS1_LSB +: `RV_REG_BITS];
    d.rs2      = w[`RV_RS2_LSB +: `RV_REG_BITS];
    case (d.opcode)
      rvPkg::OpImm, rvPkg::Jalr, rvPkg::Load: d.imm = {{20{w[31]}}, w[31:20]};
      rvPkg::Store:  d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      rvPkg::Branch: d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      rvPkg::Lui, rvPkg::Auipc: d.imm = {w[31:12], 12'b0};
      rvPkg::Jal:    d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default:       d.imm = '0;
    endcase
    return d;
  endfunction

  // Shared funct3 map of OpImm and OpReg
  function automatic rvPkg::aluOp_e arithOp(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? rvPkg::Sub : rvPkg::Add;
      3'd1:    return rvPkg::Sl;
      3'd2:    return rvPkg::LtS;
      3'd3:    return rvPkg::LtU;
      3'd4:    return rvPkg::Xor;
      3'd5:    return alt ? rvPkg::SrS : rvPkg::SrU;
      3'd6:    return rvPkg::Or;
      default: return rvPkg::And;
    endcase
  endfunction

  assign rs1 = instr.rs1;
  assign rs2 = instr.rs2;
  assign rd  = instr.rd;

  assign fetchStart = (state == rvPkg::Fetch) && !fetchPending;
  assign isMem      = (instr.opcode == rvPkg::Load) || (instr.opcode == rvPkg::Store);
  assign writesRd   = !(instr.opcode inside {rvPkg::Branch, rvPkg::Store});
  assign regWrite   = (state == rvPkg::Writeback) && writesRd;
  assign writeData  = resultReg;

  assign pcCmd.load   = (state == rvPkg::Redirect);
  assign pcCmd.target = targetReg;

  // One-cycle command, the unit registers it
  assign memCmd.valid     = (state == rvPkg::Execute) && isMem;
  assign memCmd.isStore   = (instr.opcode == rvPkg::Store);
  assign memCmd.funct3    = instr.funct3;
  assign memCmd.address   = aluResult;
  assign memCmd.storeData = rs2Data;

  always_comb
  begin
    aluX  = rs1Data;
    aluY  = instr.imm;
    aluOp = rvPkg::Add;
    case (instr.opcode)
      rvPkg::OpImm: aluOp = arithOp(instr.funct3, (instr.funct3 == 3'd5) && instr.funct7b5);
      rvPkg::OpReg:
      begin
        aluOp = arithOp(instr.funct3, instr.funct7b5);
        aluY  = rs2Data;
      end
      rvPkg::Branch:
      begin
        aluY = rs2Data;
        case (instr.funct3)
          3'd1:    aluOp = rvPkg::Ne;
          3'd4:    aluOp = rvPkg::LtS;
          3'd5:    aluOp = rvPkg::GeS;
          3'd6:    aluOp = rvPkg::LtU;
          3'd7:    aluOp = rvPkg::GeU;
          default: aluOp = rvPkg::Eq;
        endcase
      end
      rvPkg::Auipc, rvPkg::Jal: aluX = pc;
      rvPkg::Lui: aluX = '0;   // Result is the immediate itself
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state        <= rvPkg::Fetch;
      fetchPending <= 1'b0;
      retiredCount <= '0;
    end
    else
    begin
      case (state)
        rvPkg::Fetch:
        begin
          if (fetchStart)
            fetchPending <= 1'b1;
          if (fetchDone)
          begin
            fetchPending <= 1'b0;
            state        <= rvPkg::Decode;
          end
        end
        rvPkg::Decode: state <= rvPkg::Execute;
        rvPkg::Execute:
        begin
          case (instr.opcode)
            rvPkg::Load, rvPkg::Store: state <= rvPkg::Memory;
            rvPkg::Branch: state <= aluResult[0] ? rvPkg::Redirect : rvPkg::Writeback;
            rvPkg::Jal, rvPkg::Jalr: state <= rvPkg::Redirect;
            default: state <= rvPkg::Writeback;
          endcase
        end
        rvPkg::Memory:
        begin
          if (memDone)
            state <= rvPkg::Writeback;
        end
        rvPkg::Redirect: state <= rvPkg::Writeback;
        rvPkg::Writeback:
        begin
          retiredCount <= retiredCount + 64'd1;   // Every instruction ends here
          state        <= rvPkg::Fetch;
        end
        default: state <= rvPkg::Fetch;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == rvPkg::Decode)
      instr <= decodeWord(instrWord);
    if (state == rvPkg::Execute)
    begin
      if (instr.opcode == rvPkg::Jal || instr.opcode == rvPkg::Jalr)
        resultReg <= pc + 32'd4;   // Link address
      else
        resultReg <= aluResult;
      if (instr.opcode == rvPkg::Jalr)
        targetReg <= {aluResult[`RV_XLEN-1:1], 1'b0};
      else
        targetReg <= pc + instr.imm;
    end
    if (state == rvPkg::Memory && memDone)
      resultReg <= loadData;
  end

endmodule

`default_nettype wire

// File: hw/instructionFetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module instructionFetch (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  fetchStart,
  input  wire rvPkg::pcCmd_t   pcCmd,
  output rvPkg::wbReq_t        fetchReq,
  input  wire rvPkg::wbResp_t  fetchResp,
  output logic                 fetchDone,
  output logic [`RV_XLEN-1:0]  instrWord,
  output logic [`RV_XLEN-1:0]  pc
);

  logic [`RV_XLEN-1:0] nextPc;   // Address of the next fetch

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      fetchReq  <= '0;
      fetchDone <= 1'b0;
      instrWord <= `RV_NOP_WORD;
      pc        <= `RV_RESET_PC;
      nextPc    <= `RV_RESET_PC;
    end
    else
    begin
      fetchDone <= 1'b0;
      if (pcCmd.load)
        nextPc <= pcCmd.target;
      if (fetchStart)
      begin
        fetchReq.cyc  <= 1'b1;
        fetchReq.stb  <= 1'b1;
        fetchReq.we   <= 1'b0;
        fetchReq.sel  <= 4'hf;
        fetchReq.adr  <= nextPc;
        fetchReq.datW <= '0;
        pc            <= nextPc;
        nextPc        <= nextPc + 32'd4;
      end
      else if (fetchReq.cyc && fetchResp.ack)
      begin
        fetchReq.cyc <= 1'b0;   // Transfer ends on this ack
        fetchReq.stb <= 1'b0;
        instrWord    <= fetchResp.datR;
        fetchDone    <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module loadStoreUnit (
  input  wire                  clk,
  input  wire                  reset,
  input  wire rvPkg::memCmd_t  memCmd,
  output rvPkg::wbReq_t        dataReq,
  input  wire rvPkg::wbResp_t  dataResp,
  output logic                 memDone,
  output logic [`RV_XLEN-1:0]  loadData
);

  logic [1:0]           offset;
  logic [1:0]           cmdShift;    // Lowest byte lane of the access
  logic [3:0]           cmdSel;
  logic [2:0]           reqFunct3;
  logic [1:0]           reqShift;
  logic [`RV_XLEN-1:0]  laneData;
  logic [`RV_XLEN-1:0]  loadValue;

  assign offset = memCmd.address[1:0];

  always_comb
  begin
    case (memCmd.funct3[1:0])
      2'b00:
      begin
        cmdShift = offset;
        cmdSel   = 4'b0001 << offset;
      end
      2'b01:
      begin
        cmdShift = {offset[1], 1'b0};   // Halfword stays inside the word
        cmdSel   = 4'b0011 << {offset[1], 1'b0};
      end
      default:
      begin
        cmdShift = 2'd0;
        cmdSel   = 4'b1111;
      end
    endcase
  end

  assign laneData = dataResp.datR >> {reqShift, 3'b000};

  always_comb
  begin
    case (reqFunct3)
      3'b000:  loadValue = {{24{laneData[7]}}, laneData[7:0]};     // lb
      3'b001:  loadValue = {{16{laneData[15]}}, laneData[15:0]};   // lh
      3'b100:  loadValue = {24'b0, laneData[7:0]};                 // lbu
      3'b101:  loadValue = {16'b0, laneData[15:0]};                // lhu
      default: loadValue = laneData;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      dataReq <= '0;
      memDone <= 1'b0;
    end
    else
    begin
      memDone <= 1'b0;
      if (memCmd.valid)
      begin
        dataReq.cyc  <= 1'b1;
        dataReq.stb  <= 1'b1;
        dataReq.we   <= memCmd.isStore;
        dataReq.adr  <= {memCmd.address[`RV_XLEN-1:2], 2'b00};
        dataReq.sel  <= cmdSel;
        dataReq.datW <= memCmd.storeData << {cmdShift, 3'b000};
      end
      else if (dataReq.cyc && dataResp.ack)
      begin
        dataReq.cyc <= 1'b0;
        dataReq.stb <= 1'b0;
        memDone     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (memCmd.valid)
    begin
      reqFunct3 <= memCmd.funct3;
      reqShift  <= cmdShift;
    end
    if (dataReq.cyc && dataResp.ack)
      loadData <= loadValue;   // Ignored after a store
  end

endmodule

`default_nettype wire

// File: hw/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module registerFile (
  input  wire                      clk,
  input  wire                      reset,
  input  wire [`RV_REG_BITS-1:0]   rs1,
  input  wire [`RV_REG_BITS-1:0]   rs2,
  input  wire [`RV_REG_BITS-1:0]   rd,
  input  wire                      writeEnable,
  input  wire [`RV_XLEN-1:0]       writeData,
  output logic [`RV_XLEN-1:0]      rs1Data,
  output logic [`RV_XLEN-1:0]      rs2Data
);

  localparam int RegCount = 1 << `RV_REG_BITS;

  logic [`RV_XLEN-1:0] regs [RegCount];

  // x0 reads as zero whatever was written
  assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < RegCount; i++)
        regs[i] <= '0;
    end
    else if (writeEnable && rd != '0)
    begin
      regs[rd] <= writeData;
    end
  end

endmodule

`default_nettype wire

// File: hw/rvConsts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path and address width
`define RV_XLEN 32

// Register number width for 16 registers
`define RV_REG_BITS 4

// First fetch address
`define RV_RESET_PC 32'h0000_0000

// add x0, x0, x0
`define RV_NOP_WORD 32'h0000_0033

// Instruction field positions
`define RV_OPCODE_LSB 0
`define RV_RD_LSB 7
`define RV_FUNCT3_LSB 12
`define RV_RS1_LSB 15
`define RV_RS2_LSB 20
`define RV_FUNCT7B5_BIT 30

`endif

// File: hw/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module rvCore (
  input  wire                  clk,
  input  wire                  reset,
  output rvPkg::wbReq_t        busReq,
  input  wire rvPkg::wbResp_t  busResp,
  output logic [63:0]          retiredCount
);

  rvPkg::wbReq_t            fetchReq;
  rvPkg::wbResp_t           fetchResp;
  rvPkg::wbReq_t            dataReq;
  rvPkg::wbResp_t           dataResp;
  rvPkg::pcCmd_t            pcCmd;
  rvPkg::memCmd_t           memCmd;
  rvPkg::aluOp_e            aluOp;
  logic                     fetchStart;
  logic                     fetchDone;
  logic                     memDone;
  logic                     regWrite;
  logic [`RV_XLEN-1:0]      instrWord;
  logic [`RV_XLEN-1:0]      pc;
  logic [`RV_XLEN-1:0]      rs1Data;
  logic [`RV_XLEN-1:0]      rs2Data;
  logic [`RV_XLEN-1:0]      writeData;
  logic [`RV_XLEN-1:0]      aluX;
  logic [`RV_XLEN-1:0]      aluY;
  logic [`RV_XLEN-1:0]      aluResult;
  logic [`RV_XLEN-1:0]      loadData;
  logic [`RV_REG_BITS-1:0]  rs1;
  logic [`RV_REG_BITS-1:0]  rs2;
  logic [`RV_REG_BITS-1:0]  rd;

  coreControl controlUnit (
    .clk, .reset,
    .fetchStart, .fetchDone, .instrWord, .pc, .pcCmd,
    .rs1, .rs2, .rd, .rs1Data, .rs2Data,
    .regWrite, .writeData,
    .aluOp, .aluX, .aluY, .aluResult,
    .memCmd, .memDone, .loadData,
    .retiredCount
  );

  registerFile regFile (
    .clk, .reset,
    .rs1, .rs2, .rd,
    .writeEnable (regWrite),
    .writeData,
    .rs1Data, .rs2Data
  );

  aluUnit alu (.aluOp, .aluX, .aluY, .aluResult);

  instructionFetch fetchUnit (
    .clk, .reset, .fetchStart, .pcCmd, .fetchReq, .fetchResp, .fetchDone, .instrWord, .pc
  );

  loadStoreUnit lsu (.clk, .reset, .memCmd, .dataReq, .dataResp, .memDone, .loadData);

  busArbiter arbiter (
    .clk, .reset, .fetchReq, .fetchResp, .dataReq, .dataResp, .busReq, .busResp
  );

endmodule

`default_nettype wire

// File: hw/rvPkg.sv
`default_nettype none

`include "rvConsts.svh"

package rvPkg;

  typedef enum logic [6:0] {
    OpImm  = 7'b0010011,
    OpReg  = 7'b0110011,
    Branch = 7'b1100011,
    Lui    = 7'b0110111,
    Auipc  = 7'b0010111,
    Jal    = 7'b1101111,
    Jalr   = 7'b1100111,
    Load   = 7'b0000011,
    Store  = 7'b0100011
  } opcode_e;

  // Code 4'hA is left unused
  typedef enum logic [3:0] {
    Add = 4'h0,
    Sub = 4'h1,
    Or  = 4'h2,
    Xor = 4'h3,
    And = 4'h4,
    LtU = 4'h5,
    LtS = 4'h6,
    SrU = 4'h7,
    SrS = 4'h8,
    Sl  = 4'h9,
    GeU = 4'hB,
    GeS = 4'hC,
    Eq  = 4'hD,
    Ne  = 4'hE
  } aluOp_e;

  typedef enum logic [2:0] {
    Fetch,
    Decode,
    Execute,
    Writeback,
    Memory,
    Redirect
  } ctrlState_e;

  typedef struct packed {
    opcode_e                  opcode;
    logic [2:0]               funct3;
    logic                     funct7b5;
    logic [`RV_REG_BITS-1:0]  rd;
    logic [`RV_REG_BITS-1:0]  rs1;
    logic [`RV_REG_BITS-1:0]  rs2;
    logic [`RV_XLEN-1:0]      imm;      // Already sign extended
  } decodedInstr_t;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`RV_XLEN-1:0]  adr;
    logic [`RV_XLEN-1:0]  datW;
    logic [3:0]           sel;
  } wbReq_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]  datR;
    logic                 ack;
  } wbResp_t;

  typedef struct packed {
    logic                 valid;
    logic                 isStore;
    logic [2:0]           funct3;
    logic [`RV_XLEN-1:0]  address;  // Byte address, not yet aligned
    logic [`RV_XLEN-1:0]  storeData;
  } memCmd_t;

  typedef struct packed {
    logic                 load;
    logic [`RV_XLEN-1:0]  target;
  } pcCmd_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module rvCoreTb -o rvCoreSim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/rvCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log

if [ $simStatus -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1

// File: verification/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module rvCoreTb;

  localparam logic [31:0] Seed       = 32'hfa48b82d;
  localparam logic [31:0] ResultBase = 32'h0000_0800;
  localparam logic [31:0] DoneAddr   = 32'h0000_0ffc;
  localparam logic [31:0] Marker     = 32'h1234_abcd;
  localparam int          TimeoutCycles = 20000;

  logic            clk;
  logic            reset;
  logic [1:0]      ackDelay;
  rvPkg::wbReq_t   busReq;
  rvPkg::wbResp_t  busResp;
  logic [63:0]     retiredCount;
  logic [31:0]     lfsrState;
  logic [31:0]     prog[$];
  logic [31:0]     expectQ[$];

  rvCore i_dut (.clk, .reset, .busReq, .busResp, .retiredCount);

  wbMemoryModel memory (.clk, .reset, .busReq, .busResp, .ackDelay);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic nextRandom(input int bits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < bits; i++)
    begin
      value     = {value[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
  endtask

  always @(posedge clk)
  begin
    logic [31:0] r;
    nextRandom(2, r);
    ackDelay <= r[1:0];   // 0 to 3 wait cycles
  end

  task automatic compareWord(input string name, input logic [`RV_XLEN-1:0] actual,
                             input logic [`RV_XLEN-1:0] expected);
    if (actual !== expected)
    begin
      $display("Fail time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic compareCount(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("Fail time=%0t %s actual=%0d expected=%0d", $time, name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] rType(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rvPkg::OpReg};
  endfunction

  function automatic logic [31:0] iType(input rvPkg::opcode_e op, input int rd,
                                        input logic [2:0] f3, input int rs1,
                                        input logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] sType(input logic [2:0] f3, input int rs2, input int rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], rvPkg::Store};
  endfunction

  function automatic logic [31:0] bType(input logic [2:0] f3, input int rs1, input int rs2,
                                        input logic [12:0] off);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], rvPkg::Branch};
  endfunction

  function automatic logic [31:0] uType(input rvPkg::opcode_e op, input int rd,
                                        input logic [19:0] imm);
    return {imm, 5'(rd), op};
  endfunction

  function automatic logic [31:0] jType(input int rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), rvPkg::Jal};
  endfunction

  function automatic logic [31:0] pcNow();
    return 32'(prog.size() * 4);
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic loadConst(input int rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;   // Compensates the sign of the low part
    emit(uType(rvPkg::Lui, rd, upper[31:12]));
    emit(iType(rvPkg::OpImm, rd, 3'd0, rd, value[11:0]));
  endtask

  // x15 holds the result base
  task automatic storeResult(input int rs, input logic [31:0] expected);
    emit(sType(3'd2, rs, 15, 12'(4 * expectQ.size())));
    expectQ.push_back(expected);
  endtask

  task automatic beginTest();
    @(posedge clk);
    reset <= 1'b1;
    memory.fill();
    prog.delete();
    expectQ.delete();
    loadConst(15, ResultBase);
    loadConst(13, Marker);
  endtask

  task automatic runProgram(output logic [63:0] doneCount, output int instrCount);
    bit found;
    int cycles;
    found      = 0;
    cycles     = 0;
    instrCount = prog.size();
    emit(sType(3'd2, 13, 15, 12'(DoneAddr - ResultBase)));
    emit(jType(0, 21'd0));   // Park in a self loop
    for (int i = 0; i < prog.size(); i++)
      memory.writeWord(32'(i * 4), prog[i]);
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    while (!found)
    begin
      @(negedge clk);
      if (memory.peekWord(DoneAddr) == Marker)
        found = 1;
      else if (cycles++ > TimeoutCycles)
      begin
        $display("Timeout while waiting for the program to store its done marker");
        $display("SIMULATION FAILED");
        $fatal(1);
      end
    end
    doneCount = retiredCount;
    for (int i = 0; i < expectQ.size(); i++)
      compareWord($sformatf("result[%0d]", i), memory.peekWord(ResultBase + 32'(4 * i)),
                  expectQ[i]);
  endtask

  task automatic checkAluOps();
    logic [31:0] a, b, r, immI;
    logic [63:0] cnt;
    logic [4:0]  sh;
    int          n;
    beginTest();
    nextRandom(32, a);
    nextRandom(32, b);
    nextRandom(12, r);
    immI = {{20{r[11]}}, r[11:0]};
    sh   = b[4:0];
    loadConst(1, a);
    loadConst(2, b);
    emit(iType(rvPkg::OpImm, 4, 3'd0, 1, r[11:0]));
    storeResult(4, a + immI);
    emit(iType(rvPkg::OpImm, 4, 3'd2, 1, r[11:0]));
    storeResult(4, {31'b0, $signed(a) < $signed(immI)});
    emit(iType(rvPkg::OpImm, 4, 3'd3, 1, r[11:0]));
    storeResult(4, {31'b0, a < immI});
    emit(iType(rvPkg::OpImm, 4, 3'd4, 1, r[11:0]));
    storeResult(4, a ^ immI);
    emit(iType(rvPkg::OpImm, 4, 3'd6, 1, r[11:0]));
    storeResult(4, a | immI);
    emit(iType(rvPkg::OpImm, 4, 3'd7, 1, r[11:0]));
    storeResult(4, a & immI);
    emit(iType(rvPkg::OpImm, 4, 3'd1, 1, {7'b0, sh}));
    storeResult(4, a << sh);
    emit(iType(rvPkg::OpImm, 4, 3'd5, 1, {7'b0, sh}));
    storeResult(4, a >> sh);
    emit(iType(rvPkg::OpImm, 4, 3'd5, 1, {7'b0100000, sh}));   // srai
    storeResult(4, $signed(a) >>> sh);
    emit(rType(7'd0, 2, 1, 3'd0, 4));
    storeResult(4, a + b);
    emit(rType(7'b0100000, 2, 1, 3'd0, 4));
    storeResult(4, a - b);
    emit(rType(7'd0, 2, 1, 3'd1, 4));
    storeResult(4, a << sh);
    emit(rType(7'd0, 2, 1, 3'd2, 4));
    storeResult(4, {31'b0, $signed(a) < $signed(b)});
    emit(rType(7'd0, 2, 1, 3'd3, 4));
    storeResult(4, {31'b0, a < b});
    emit(rType(7'd0, 2, 1, 3'd4, 4));
    storeResult(4, a ^ b);
    emit(rType(7'd0, 2, 1, 3'd5, 4));
    storeResult(4, a >> sh);
    emit(rType(7'b0100000, 2, 1, 3'd5, 4));
    storeResult(4, $signed(a) >>> sh);
    emit(rType(7'd0, 2, 1, 3'd6, 4));
    storeResult(4, a | b);
    emit(rType(7'd0, 2, 1, 3'd7, 4));
    storeResult(4, a & b);
    runProgram(cnt, n);
  endtask

  task automatic checkUpperAndZero();
    logic [31:0] u, p;
    logic [63:0] cnt;
    int          n;
    beginTest();
    nextRandom(20, u);
    emit(uType(rvPkg::Lui, 4, u[19:0]));
    storeResult(4, {u[19:0], 12'b0});
    p = pcNow();
    emit(uType(rvPkg::Auipc, 4, u[19:0]));
    storeResult(4, p + {u[19:0], 12'b0});
    emit(iType(rvPkg::OpImm, 0, 3'd0, 0, 12'h123));   // Write to x0 is dropped
    storeResult(0, 32'd0);
    emit(rType(7'd0, 0, 0, 3'd0, 4));
    storeResult(4, 32'd0);
    runProgram(cnt, n);
  endtask

  function automatic bit branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic checkBranches();
    logic [31:0] aVals[3];
    logic [31:0] bVals[3];
    logic [2:0]  codes[6];
    logic [63:0] cnt;
    int          n;
    int          k;
    aVals = '{32'd7, 32'hffff_fffd, 32'd5};
    bVals = '{32'd7, 32'd5, 32'hffff_fffd};
    codes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    k = 0;
    beginTest();
    for (int c = 0; c < 6; c++)
    begin
      for (int p = 0; p < 3; p++)
      begin
        loadConst(1, aVals[p]);
        loadConst(2, bVals[p]);
        emit(bType(codes[c], 1, 2, 13'd12));
        emit(iType(rvPkg::OpImm, 4, 3'd0, 0, 12'(512 + k)));   // Fall-through path
        emit(jType(0, 21'd8));
        emit(iType(rvPkg::OpImm, 4, 3'd0, 0, 12'(256 + k)));   // Taken path
        storeResult(4, branchTaken(codes[c], aVals[p], bVals[p]) ? 32'(256 + k) : 32'(512 + k));
        k++;
      end
    end
    runProgram(cnt, n);
  endtask

  task automatic checkJumps();
    logic [31:0] p;
    logic [31:0] q;
    logic [63:0] cnt;
    int          n;
    beginTest();
    emit(iType(rvPkg::OpImm, 4, 3'd0, 0, 12'h066));
    p = pcNow();
    emit(jType(5, 21'd8));
    emit(iType(rvPkg::OpImm, 4, 3'd0, 0, 12'h055));   // Skipped
    storeResult(5, p + 32'd4);
    storeResult(4, 32'h66);
    q = pcNow() + 32'd8;
    loadConst(6, q + 32'd9);   // Odd target whose bit 0 is dropped
    emit(iType(rvPkg::Jalr, 7, 3'd0, 6, 12'd0));
    emit(iType(rvPkg::OpImm, 4, 3'd0, 0, 12'h055));   // Skipped
    emit(uType(rvPkg::Auipc, 8, 20'd0));   // Reports the landing address
    storeResult(8, q + 32'd8);
    storeResult(7, q + 32'd4);
    storeResult(4, 32'h66);
    runProgram(cnt, n);
  endtask

  task automatic checkMemoryAccess();
    logic [31:0] x1, x2, x3, x9, w0, w1, w3;
    logic [63:0] cnt;
    int          n;
    beginTest();
    nextRandom(32, x1);
    nextRandom(32, x2);
    nextRandom(32, x3);
    nextRandom(32, x9);
    x1 = x1 | 32'h0000_8080;   // Negative byte and halfword
    x2 = x2 & 32'h7f7f_7f7f;
    w3 = memory.peekWord(32'h90c);
    w3[23:16] = x9[7:0];
    w0 = {x9[7:0], x3[7:0], x2[7:0], x1[7:0]};
    w1 = {x2[15:0], x1[15:0]};
    loadConst(8, 32'h900);
    loadConst(1, x1);
    loadConst(2, x2);
    loadConst(3, x3);
    loadConst(9, x9);
    emit(sType(3'd0, 1, 8, 12'd0));
    emit(sType(3'd0, 2, 8, 12'd1));
    emit(sType(3'd0, 3, 8, 12'd2));
    emit(sType(3'd0, 9, 8, 12'd3));
    emit(sType(3'd1, 1, 8, 12'd4));
    emit(sType(3'd1, 2, 8, 12'd6));
    emit(sType(3'd2, 3, 8, 12'd8));
    emit(sType(3'd0, 9, 8, 12'd14));
    for (int b = 0; b < 4; b++)
    begin
      emit(iType(rvPkg::Load, 4, 3'd0, 8, 12'(b)));
      storeResult(4, {{24{w0[8*b+7]}}, w0[8*b +: 8]});
      emit(iType(rvPkg::Load, 4, 3'd4, 8, 12'(b)));
      storeResult(4, {24'b0, w0[8*b +: 8]});
    end
    for (int h = 0; h < 2; h++)
    begin
      emit(iType(rvPkg::Load, 4, 3'd1, 8, 12'(4 + 2 * h)));
      storeResult(4, {{16{w1[16*h+15]}}, w1[16*h +: 16]});
      emit(iType(rvPkg::Load, 4, 3'd5, 8, 12'(4 + 2 * h)));
      storeResult(4, {16'b0, w1[16*h +: 16]});
    end
    emit(iType(rvPkg::Load, 4, 3'd2, 8, 12'd8));
    storeResult(4, x3);
    emit(iType(rvPkg::Load, 4, 3'd2, 8, 12'd12));
    storeResult(4, w3);
    runProgram(cnt, n);
    compareWord("mem[0x900]", memory.peekWord(32'h900), w0);
    compareWord("mem[0x904]", memory.peekWord(32'h904), w1);
    compareWord("mem[0x908]", memory.peekWord(32'h908), x3);
    compareWord("mem[0x90c]", memory.peekWord(32'h90c), w3);
  endtask

  task automatic checkRetiredCount();
    logic [63:0] cnt;
    int          n;
    beginTest();
    for (int i = 0; i < 10; i++)
      emit(iType(rvPkg::OpImm, 4, 3'd0, 4, 12'd1));
    storeResult(4, 32'd10);
    runProgram(cnt, n);
    compareCount("retiredCount", cnt, 64'(n));
  endtask

  initial
  begin
    reset      = 1'b1;
    ackDelay   = 2'd0;
    lfsrState  = Seed;
    checkAluOps();
    checkAluOps();
    checkUpperAndZero();
    checkBranches();
    checkJumps();
    checkMemoryAccess();
    checkRetiredCount();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/wbMemoryModel.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module wbMemoryModel (
  input  wire                  clk,
  input  wire                  reset,
  input  wire rvPkg::wbReq_t   busReq,
  output rvPkg::wbResp_t       busResp,
  input  wire [1:0]            ackDelay
);

  localparam int Words = 1024;   // 4 KB, wraps above

  logic [`RV_XLEN-1:0] mem [Words];
  logic                busy;
  logic [1:0]          waitCount;
  logic [9:0]          index;

  assign index = busReq.adr[11:2];

  // Every word gets a value tied to its full byte address
  function automatic logic [`RV_XLEN-1:0] fillValue(input logic [`RV_XLEN-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
  endfunction

  task automatic fill();
    for (int i = 0; i < Words; i++)
      mem[i] = fillValue(32'(i) << 2);
  endtask

  task automatic writeWord(input logic [`RV_XLEN-1:0] addr, input logic [`RV_XLEN-1:0] data);
    mem[addr[11:2]] = data;
  endtask

  function automatic logic [`RV_XLEN-1:0] peekWord(input logic [`RV_XLEN-1:0] addr);
    return mem[addr[11:2]];
  endfunction

  always @(posedge clk)
  begin
    if (reset)
    begin
      busy    <= 1'b0;
      busResp <= '0;
    end
    else if (busResp.ack)
      busResp.ack <= 1'b0;   // One ack per transfer
    else if (busReq.cyc && busReq.stb)
    begin
      if (!busy)
      begin
        busy      <= 1'b1;
        waitCount <= ackDelay;
      end
      else if (waitCount == 2'd0)
      begin
        busy        <= 1'b0;
        busResp.ack <= 1'b1;
        busResp.datR <= mem[index];
        if (busReq.we)
        begin
          for (int b = 0; b < 4; b++)
            if (busReq.sel[b])
              mem[index][8*b +: 8] <= busReq.datW[8*b +: 8];
        end
      end
      else
        waitCount <= waitCount - 2'd1;
    end
  end

endmodule

`default_nettype wire
